//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary -sv --assert -Wno-fatal --top-module tb_top -f src.f -Mdir obj_dir -o Vtb_top

run: compile
	./obj_dir/Vtb_top > sim.log 2>&1; cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" sim.log || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- src.f
src/brisc_pkg.sv
src/brisc_mem_pkg.sv
src/cache.sv
src/store_buffer.sv
src/mem_port.sv
src/dcache_ctrl.sv
src/dcache_top.sv
tb/tb_clk_gen.sv
tb/tb_mem_model.sv
tb/tb_checker.sv
tb/tb_top.sv

//--- src/brisc_mem_pkg.sv
package brisc_mem_pkg;

  import brisc_pkg::*;

  typedef enum logic {
    W,
    B
  } data_size_e;

  typedef enum logic {
    LOAD,
    STORE
  } mem_op_e;

  typedef enum logic [2:0] {
    IDLE,
    DRAIN,
    LOOKUP,
    EVICT,
    FILL_REQ,
    FILL_WAIT,
    RESPOND
  } ctrl_state_e;

  // one request from the core
  typedef struct packed {
    mem_op_e op;
    data_size_e size;
    logic [ADDRESS_WIDTH-1:0] addr;
    logic [XLEN-1:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic [ADDRESS_WIDTH-1:0] addr;
    logic [XLEN-1:0] data;
    data_size_e size;
  } store_entry_t;

  // line address has its offset bits at zero
  typedef struct packed {
    logic [ADDRESS_WIDTH-1:0] addr;
    logic [CACHE_LINE_WIDTH-1:0] data;
  } mem_line_t;

endpackage

//--- src/brisc_pkg.sv
package brisc_pkg;

  // core and address geometry
  localparam int unsigned ADDRESS_WIDTH = 16;
  localparam int unsigned XLEN = 32;
  localparam int unsigned WORD_WIDTH = 32;
  localparam int unsigned BYTE_WIDTH = 8;

  // direct-mapped cache shape
  localparam int unsigned NUM_CACHE_LINES = 8;
  localparam int unsigned CACHE_LINE_WIDTH = 128;

  // address split: tag | set | offset
  localparam int unsigned SET_WIDTH = $clog2(NUM_CACHE_LINES);
  localparam int unsigned OFFSET_WIDTH = $clog2(CACHE_LINE_WIDTH / BYTE_WIDTH);
  localparam int unsigned TAG_WIDTH = ADDRESS_WIDTH - SET_WIDTH - OFFSET_WIDTH;

  // offset split: word within line, byte within word
  localparam int unsigned BYTE_OFFSET_WIDTH = $clog2(WORD_WIDTH / BYTE_WIDTH);
  localparam int unsigned WORD_OFFSET_WIDTH = $clog2(CACHE_LINE_WIDTH / WORD_WIDTH);

endpackage

//--- src/cache.sv
`timescale 1ns/1ps

module cache
  import brisc_pkg::*;
  import brisc_mem_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic [ADDRESS_WIDTH-1:0]    lookup_addr,
  input  logic                        is_mem,
  input  logic                        cache_write,
  input  store_entry_t                store,
  input  logic                        fill,
  input  mem_line_t                   fill_line,
  output logic                        miss,
  output logic                        evict,
  output mem_line_t                   evict_line,
  output logic [CACHE_LINE_WIDTH-1:0] read_data
);

  logic [NUM_CACHE_LINES-1:0] valid_q;
  logic [NUM_CACHE_LINES-1:0] dirty_q;
  logic [TAG_WIDTH-1:0] tag_q [NUM_CACHE_LINES];
  logic [CACHE_LINE_WIDTH-1:0] data_q [NUM_CACHE_LINES];

  logic [SET_WIDTH-1:0] look_set;
  logic [SET_WIDTH-1:0] store_set;
  logic [SET_WIDTH-1:0] fill_set;
  logic [SET_WIDTH-1:0] acc_set;
  logic [TAG_WIDTH-1:0] look_tag;
  logic [TAG_WIDTH-1:0] store_tag;
  logic [TAG_WIDTH-1:0] fill_tag;
  logic [TAG_WIDTH-1:0] acc_tag;
  logic [WORD_OFFSET_WIDTH-1:0] word_off;
  logic [OFFSET_WIDTH-1:0] byte_off;
  logic [CACHE_LINE_WIDTH-1:0] merged_line;

  function automatic logic [SET_WIDTH-1:0] addr_set(input logic [ADDRESS_WIDTH-1:0] a);
    return a[SET_WIDTH+OFFSET_WIDTH-1:OFFSET_WIDTH];
  endfunction

  function automatic logic [TAG_WIDTH-1:0] addr_tag(input logic [ADDRESS_WIDTH-1:0] a);
    return a[ADDRESS_WIDTH-1:SET_WIDTH+OFFSET_WIDTH];
  endfunction

  assign look_set = addr_set(lookup_addr);
  assign look_tag = addr_tag(lookup_addr);
  assign store_set = addr_set(store.addr);
  assign store_tag = addr_tag(store.addr);
  assign fill_set = addr_set(fill_line.addr);
  assign fill_tag = addr_tag(fill_line.addr);

  // a write checks the store address, anything else the lookup address
  assign acc_set = cache_write ? store_set : look_set;
  assign acc_tag = cache_write ? store_tag : look_tag;

  assign miss = is_mem & ~(valid_q[acc_set] & (tag_q[acc_set] == acc_tag));
  assign evict = miss & valid_q[acc_set] & dirty_q[acc_set];
  assign evict_line.addr = {tag_q[acc_set], acc_set, {OFFSET_WIDTH{1'b0}}};
  assign evict_line.data = data_q[acc_set];

  assign read_data = data_q[look_set];

  assign word_off = store.addr[WORD_OFFSET_WIDTH+BYTE_OFFSET_WIDTH-1:BYTE_OFFSET_WIDTH];
  assign byte_off = store.addr[OFFSET_WIDTH-1:0];

  always_comb begin
    merged_line = data_q[store_set];
    if (store.size == W) begin
      merged_line[word_off*WORD_WIDTH+:WORD_WIDTH] = store.data;
    end else begin
      // byte stores carry their byte in the low lane
      merged_line[byte_off*BYTE_WIDTH+:BYTE_WIDTH] = store.data[BYTE_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill) begin
      valid_q[fill_set] <= 1'b1;
      dirty_q[fill_set] <= 1'b0;
    end else if (cache_write) begin
      dirty_q[store_set] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fill) begin
      tag_q[fill_set] <= fill_tag;
      data_q[fill_set] <= fill_line.data;
    end else if (cache_write) begin
      data_q[store_set] <= merged_line;
    end
  end

  // the controller must serialize fills and drain writes
  assert property (@(posedge clk) disable iff (reset) !(fill && cache_write));

  // drain writes only land on a line already resident
  assert property (@(posedge clk) disable iff (reset) cache_write |-> !miss);

endmodule

//--- src/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl
  import brisc_pkg::*;
  import brisc_mem_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req,
  input  core_req_t                   req_data,
  output logic                        busy,
  output logic                        rvalid,
  output logic [XLEN-1:0]             rdata,
  output logic [ADDRESS_WIDTH-1:0]    lookup_addr,
  output logic                        is_mem,
  output logic                        cache_write,
  output logic                        fill,
  input  logic                        miss,
  input  logic                        evict,
  input  logic [CACHE_LINE_WIDTH-1:0] read_data,
  output logic                        push,
  output store_entry_t                push_entry,
  output logic                        pop,
  input  logic                        sb_empty,
  input  logic                        sb_full,
  input  store_entry_t                sb_head,
  output logic                        wb_strobe,
  output logic                        rd_strobe,
  output logic [ADDRESS_WIDTH-1:0]    rd_addr,
  input  logic                        fill_ready
);

  ctrl_state_e state_q;
  ctrl_state_e state_n;
  logic pend_q;
  core_req_t pend_req_q;
  logic drain_q;
  logic drain_n;
  logic load_req;
  logic [WORD_OFFSET_WIDTH-1:0] word_sel;
  logic [OFFSET_WIDTH-1:0] byte_sel;
  logic [WORD_WIDTH-1:0] load_word;
  logic [BYTE_WIDTH-1:0] load_byte;

  assign load_req = req && (req_data.op == LOAD);
  assign push = req && (req_data.op == STORE);
  assign push_entry = '{addr: req_data.addr, data: req_data.wdata, size: req_data.size};

  // stores go straight to the buffer, so only a held load or a full buffer stalls the core
  assign busy = pend_q || sb_full;

  assign lookup_addr = drain_q ? sb_head.addr : pend_req_q.addr;
  assign rd_addr = {lookup_addr[ADDRESS_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
  assign is_mem = (state_q != IDLE);
  assign wb_strobe = (state_q == EVICT);
  assign rd_strobe = (state_q == FILL_REQ);
  assign fill = (state_q == FILL_WAIT) && fill_ready;
  assign cache_write = (state_q == DRAIN);
  assign pop = (state_q == DRAIN);
  assign rvalid = (state_q == RESPOND);

  assign word_sel = pend_req_q.addr[WORD_OFFSET_WIDTH+BYTE_OFFSET_WIDTH-1:BYTE_OFFSET_WIDTH];
  assign byte_sel = pend_req_q.addr[OFFSET_WIDTH-1:0];
  assign load_word = read_data[word_sel*WORD_WIDTH+:WORD_WIDTH];
  assign load_byte = read_data[byte_sel*BYTE_WIDTH+:BYTE_WIDTH];
  assign rdata = (pend_req_q.size == W) ? load_word : {{(XLEN-BYTE_WIDTH){1'b0}}, load_byte};

  always_comb begin
    state_n = state_q;
    drain_n = drain_q;
    case (state_q)
      IDLE: begin
        // a load only goes once every older store is in the cache
        if ((load_req || pend_q) && sb_empty) begin
          state_n = LOOKUP;
          drain_n = 1'b0;
        end else if (!sb_empty) begin
          state_n = LOOKUP;
          drain_n = 1'b1;
        end
      end
      LOOKUP: begin
        if (miss) begin
          state_n = evict ? EVICT : FILL_REQ;
        end else begin
          state_n = drain_q ? DRAIN : RESPOND;
        end
      end
      EVICT: state_n = FILL_REQ;
      FILL_REQ: state_n = FILL_WAIT;
      FILL_WAIT: begin
        if (fill_ready) begin
          state_n = LOOKUP;
        end
      end
      DRAIN: state_n = IDLE;
      RESPOND: state_n = IDLE;
      default: state_n = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= IDLE;
      drain_q <= 1'b0;
      pend_q <= 1'b0;
    end else begin
      state_q <= state_n;
      drain_q <= drain_n;
      if (load_req) begin
        pend_q <= 1'b1;
      end else if (state_q == RESPOND) begin
        pend_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_req) begin
      pend_req_q <= req_data;
    end
  end

  // a load lookup never overtakes buffered stores
  assert property (@(posedge clk) disable iff (reset)
    (state_q == LOOKUP && !drain_q) |-> sb_empty);

  // the core only asks while the cache is free
  assert property (@(posedge clk) disable iff (reset) req |-> !busy);

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
  import brisc_pkg::*;
  import brisc_mem_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        req,
  input  core_req_t                   req_data,
  output logic                        busy,
  output logic                        rvalid,
  output logic [XLEN-1:0]             rdata,
  output logic                        mem_rd,
  output logic [ADDRESS_WIDTH-1:0]    mem_rd_addr,
  output logic                        mem_wr,
  output mem_line_t                   mem_wr_line,
  input  logic                        mem_rvalid,
  input  logic [CACHE_LINE_WIDTH-1:0] mem_rdata
);

  logic [ADDRESS_WIDTH-1:0] lookup_addr;
  logic is_mem;
  logic cache_write;
  logic fill;
  logic miss;
  logic evict;
  mem_line_t evict_line;
  logic [CACHE_LINE_WIDTH-1:0] read_data;
  logic push;
  store_entry_t push_entry;
  logic pop;
  logic sb_empty;
  logic sb_full;
  store_entry_t sb_head;
  logic wb_strobe;
  logic rd_strobe;
  logic [ADDRESS_WIDTH-1:0] rd_addr;
  logic fill_ready;
  mem_line_t fill_line;

  dcache_ctrl ctrl_inst (
    .clk, .reset, .req, .req_data, .busy, .rvalid, .rdata,
    .lookup_addr, .is_mem, .cache_write, .fill, .miss, .evict, .read_data,
    .push, .push_entry, .pop, .sb_empty, .sb_full, .sb_head,
    .wb_strobe, .rd_strobe, .rd_addr, .fill_ready
  );

  cache cache_inst (
    .clk, .reset, .lookup_addr, .is_mem, .cache_write,
    .store(sb_head), .fill, .fill_line, .miss, .evict, .evict_line, .read_data
  );

  store_buffer sb_inst (
    .clk, .reset, .push, .push_entry, .pop,
    .head(sb_head), .empty(sb_empty), .full(sb_full)
  );

  mem_port mem_port_inst (
    .clk, .reset, .wb_strobe, .wb_line(evict_line), .rd_strobe, .rd_addr,
    .mem_wr, .mem_wr_line, .mem_rd, .mem_rd_addr, .mem_rvalid, .mem_rdata,
    .fill_ready, .fill_line
  );

endmodule

//--- src/mem_port.sv
`timescale 1ns/1ps

module mem_port
  import brisc_pkg::*;
  import brisc_mem_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        wb_strobe,
  input  mem_line_t                   wb_line,
  input  logic                        rd_strobe,
  input  logic [ADDRESS_WIDTH-1:0]    rd_addr,
  output logic                        mem_wr,
  output mem_line_t                   mem_wr_line,
  output logic                        mem_rd,
  output logic [ADDRESS_WIDTH-1:0]    mem_rd_addr,
  input  logic                        mem_rvalid,
  input  logic [CACHE_LINE_WIDTH-1:0] mem_rdata,
  output logic                        fill_ready,
  output mem_line_t                   fill_line
);

  // one read in flight at most
  logic rd_pending_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wr <= 1'b0;
      mem_rd <= 1'b0;
      fill_ready <= 1'b0;
      rd_pending_q <= 1'b0;
    end else begin
      mem_wr <= wb_strobe;
      mem_rd <= rd_strobe;
      fill_ready <= mem_rvalid;
      if (rd_strobe) begin
        rd_pending_q <= 1'b1;
      end else if (mem_rvalid) begin
        rd_pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_strobe) begin
      mem_wr_line <= wb_line;
    end
    if (rd_strobe) begin
      mem_rd_addr <= rd_addr;
    end
    if (mem_rvalid) begin
      fill_line <= '{addr: mem_rd_addr, data: mem_rdata};
    end
  end

  assert property (@(posedge clk) disable iff (reset) mem_rvalid |-> rd_pending_q);

endmodule

//--- src/store_buffer.sv
`timescale 1ns/1ps

module store_buffer
  import brisc_mem_pkg::*;
#(
  parameter int unsigned DEPTH = 4
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         push,
  input  store_entry_t push_entry,
  input  logic         pop,
  output store_entry_t head,
  output logic         empty,
  output logic         full
);

  store_entry_t entries [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0] count_q;

  assign head = entries[rd_ptr_q];
  assign empty = (count_q == '0);
  assign full = (count_q == ($clog2(DEPTH+1))'(DEPTH));

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (push) begin
        if (wr_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop) begin
        if (rd_ptr_q == ($clog2(DEPTH))'(DEPTH - 1)) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      entries[wr_ptr_q] <= push_entry;
    end
  end

  // busy must hold the core off once the buffer fills
  assert property (@(posedge clk) disable iff (reset) push |-> !full);

  assert property (@(posedge clk) disable iff (reset) pop |-> !empty);

endmodule

//--- tb/tb_checker.sv
`timescale 1ns/1ps

module tb_checker
  import brisc_pkg::*;
  import brisc_mem_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     req,
  input  core_req_t                req_data,
  input  logic                     busy,
  input  logic                     rvalid,
  input  logic [XLEN-1:0]          rdata,
  input  logic                     mem_rd,
  input  logic [ADDRESS_WIDTH-1:0] mem_rd_addr,
  input  logic                     mem_wr,
  input  mem_line_t                mem_wr_line,
  input  logic                     mem_rvalid,
  input  logic                     drain_pop,
  input  logic                     hit_expected,
  output int                       error_count
);

  // store buffer depth of the DUT
  localparam int unsigned SB_DEPTH = 4;

  // core view holds every sampled store, drained view only those already popped
  logic [7:0] core_mem [1 << ADDRESS_WIDTH];
  logic [7:0] drained_mem [1 << ADDRESS_WIDTH];
  core_req_t pending_stores [$];
  logic started;
  logic load_pend;
  logic rd_out;
  logic hit_load;
  int load_cycles;
  logic [XLEN-1:0] expected;
  core_req_t load_req;

  task automatic apply_store(input core_req_t s, input bit to_core);
    logic [ADDRESS_WIDTH-1:0] a;
    a = s.addr;
    if (s.size == W) begin
      a[1:0] = 2'b00;
      for (int i = 0; i < 4; i++) begin
        if (to_core) core_mem[a + i] = s.wdata[i*8+:8];
        else drained_mem[a + i] = s.wdata[i*8+:8];
      end
    end else if (to_core) begin
      core_mem[a] = s.wdata[7:0];
    end else begin
      drained_mem[a] = s.wdata[7:0];
    end
  endtask

  function automatic logic [XLEN-1:0] model_load(input core_req_t r);
    logic [ADDRESS_WIDTH-1:0] a;
    a = r.addr;
    if (r.size == B) return {24'h0, core_mem[a]};
    a[1:0] = 2'b00;
    return {core_mem[a + 3], core_mem[a + 2], core_mem[a + 1], core_mem[a]};
  endfunction

  initial begin
    logic [ADDRESS_WIDTH-1:0] a;
    error_count = 0;
    started = 1'b0;
    load_pend = 1'b0;
    rd_out = 1'b0;
    hit_load = 1'b0;
    load_cycles = 0;
    expected = '0;
    for (int i = 0; i < (1 << ADDRESS_WIDTH); i++) begin
      a = ADDRESS_WIDTH'(i);
      core_mem[i] = a[7:0] ^ {a[11:8], a[15:12]} ^ 8'ha5;
      drained_mem[i] = core_mem[i];
    end
  end

  always @(negedge clk) begin
    logic [7:0] b;
    logic exp_busy;
    logic [ADDRESS_WIDTH-1:0] exp_line;
    if (!reset) begin
      // busy follows a held load or a full buffer
      exp_busy = load_pend || (pending_stores.size() == SB_DEPTH);
      if (busy !== exp_busy) begin
        error_count++;
        $display("error %0t: busy is %b, expected %b", $time, busy, exp_busy);
      end
      if (!started && !req && (busy || rvalid || mem_rd || mem_wr)) begin
        error_count++;
        $display("error %0t: outputs active before the first request", $time);
      end
      if (mem_wr) begin
        for (int i = 0; i < CACHE_LINE_WIDTH / 8; i++) begin
          b = drained_mem[mem_wr_line.addr + i];
          if (mem_wr_line.data[i*8+:8] !== b) begin
            error_count++;
            $display("error %0t: write-back line %h byte %0d is %h, expected %h",
                     $time, mem_wr_line.addr, i, mem_wr_line.data[i*8+:8], b);
          end
        end
      end
      if (drain_pop) begin
        if (pending_stores.size() == 0) begin
          error_count++;
          $display("error %0t: store buffer drained a store that was never issued", $time);
        end else begin
          apply_store(pending_stores.pop_front(), 1'b0);
        end
      end
      if (mem_rd) begin
        rd_out = 1'b1;
        // the oldest buffered store goes first, else the held load
        if (pending_stores.size() != 0) begin
          exp_line = pending_stores[0].addr;
        end else begin
          exp_line = load_req.addr;
        end
        exp_line = (exp_line >> OFFSET_WIDTH) << OFFSET_WIDTH;
        if (pending_stores.size() == 0 && !load_pend) begin
          error_count++;
          $display("error %0t: line read with no access waiting", $time);
        end else if (mem_rd_addr !== exp_line) begin
          error_count++;
          $display("error %0t: line read at %h, expected %h", $time, mem_rd_addr, exp_line);
        end
      end
      if (mem_rvalid) rd_out = 1'b0;
      if (load_pend) load_cycles++;
      if (rvalid) begin
        if (!load_pend) begin
          error_count++;
          $display("error %0t: rvalid without a pending load", $time);
        end else if (rd_out) begin
          error_count++;
          $display("error %0t: rvalid while a line read was outstanding", $time);
        end else if (rdata !== expected) begin
          error_count++;
          $display("error %0t: load at %h returned %h, expected %h",
                   $time, load_req.addr, rdata, expected);
        end
        if (load_pend && hit_load && load_cycles != 2) begin
          error_count++;
          $display("error %0t: hit load took %0d cycles to rvalid, expected 2",
                   $time, load_cycles);
        end
        load_pend = 1'b0;
      end
      if (req) begin
        started = 1'b1;
        if (req_data.op == STORE) begin
          apply_store(req_data, 1'b1);
          pending_stores.push_back(req_data);
        end else begin
          load_req = req_data;
          expected = model_load(req_data);
          load_pend = 1'b1;
          load_cycles = 0;
          hit_load = hit_expected;
        end
      end
    end
  end

endmodule

//--- tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // reset spans the first 5 rising edges
  initial begin
    reset = 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- tb/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model
  import brisc_pkg::*;
  import brisc_mem_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        mem_rd,
  input  logic [ADDRESS_WIDTH-1:0]    mem_rd_addr,
  input  logic                        mem_wr,
  input  mem_line_t                   mem_wr_line,
  output logic                        mem_rvalid,
  output logic [CACHE_LINE_WIDTH-1:0] mem_rdata
);

  localparam int unsigned NUM_LINES = 1 << (ADDRESS_WIDTH - OFFSET_WIDTH);

  logic [CACHE_LINE_WIDTH-1:0] lines [NUM_LINES];
  logic [31:0] delay_state;
  logic rd_pend;
  logic [ADDRESS_WIDTH-1:0] rd_addr;
  int delay;

  function automatic int next_delay();
    delay_state = delay_state * 32'd1103515245 + 32'd12345;
    return 1 + int'(delay_state[18:16]);
  endfunction

  initial begin
    logic [ADDRESS_WIDTH-1:0] a;
    delay_state = 32'd33393;
    mem_rvalid = 1'b0;
    mem_rdata = '0;
    rd_pend = 1'b0;
    rd_addr = '0;
    delay = 0;
    for (int i = 0; i < (1 << ADDRESS_WIDTH); i++) begin
      a = ADDRESS_WIDTH'(i);
      // every byte is a function of its full address
      lines[a >> OFFSET_WIDTH][a[OFFSET_WIDTH-1:0]*8+:8] = a[7:0] ^ {a[11:8], a[15:12]} ^ 8'ha5;
    end
  end

  always @(posedge clk) begin
    mem_rvalid <= 1'b0;
    if (reset) begin
      rd_pend = 1'b0;
    end else begin
      if (mem_wr) begin
        lines[mem_wr_line.addr >> OFFSET_WIDTH] <= mem_wr_line.data;
      end
      if (mem_rd) begin
        rd_pend = 1'b1;
        rd_addr = mem_rd_addr;
        delay = next_delay();
      end else if (rd_pend) begin
        delay = delay - 1;
        if (delay == 0) begin
          mem_rvalid <= 1'b1;
          mem_rdata <= lines[rd_addr >> OFFSET_WIDTH];
          rd_pend = 1'b0;
        end
      end
    end
  end

endmodule

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import brisc_pkg::*;
  import brisc_mem_pkg::*;

  localparam int WAIT_LIMIT = 2000;

  logic clk;
  logic reset;
  logic req;
  core_req_t req_data;
  logic busy;
  logic rvalid;
  logic [XLEN-1:0] rdata;
  logic mem_rd;
  logic [ADDRESS_WIDTH-1:0] mem_rd_addr;
  logic mem_wr;
  mem_line_t mem_wr_line;
  logic mem_rvalid;
  logic [CACHE_LINE_WIDTH-1:0] mem_rdata;
  logic expect_hit;
  int error_count;
  int timeouts;
  logic [31:0] rng_state;
  logic [31:0] r;

  tb_clk_gen clk_gen_inst (.clk, .reset);

  dcache_top dcache_top_inst (
    .clk, .reset, .req, .req_data, .busy, .rvalid, .rdata,
    .mem_rd, .mem_rd_addr, .mem_wr, .mem_wr_line, .mem_rvalid, .mem_rdata
  );

  tb_mem_model mem_model_inst (
    .clk, .reset, .mem_rd, .mem_rd_addr, .mem_wr, .mem_wr_line, .mem_rvalid, .mem_rdata
  );

  tb_checker checker_inst (
    .clk, .reset, .req, .req_data, .busy, .rvalid, .rdata, .mem_rd, .mem_rd_addr, .mem_wr,
    .mem_wr_line, .mem_rvalid, .drain_pop(dcache_top_inst.pop), .hit_expected(expect_hit),
    .error_count
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  task automatic wait_not_busy();
    int n;
    n = 0;
    while (timeouts == 0 && n < WAIT_LIMIT) begin
      @(negedge clk);
      if (!busy) break;
      n++;
    end
    if (n == WAIT_LIMIT) begin
      timeouts++;
      $display("timeout: busy stayed high for %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic wait_rvalid();
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (timeouts == 0 && !seen && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
      seen = rvalid;
    end
    if (timeouts == 0 && !seen) begin
      timeouts++;
      $display("timeout: no rvalid for a load within %0d cycles", WAIT_LIMIT);
    end
  endtask

  task automatic issue(input mem_op_e op, input data_size_e size,
                       input logic [ADDRESS_WIDTH-1:0] addr, input logic [XLEN-1:0] wdata);
    wait_not_busy();
    if (timeouts == 0) begin
      @(posedge clk);
      req <= 1'b1;
      req_data <= '{op: op, size: size, addr: addr, wdata: wdata};
      @(posedge clk);
      req <= 1'b0;
      if (op == LOAD) wait_rvalid();
    end
  endtask

  initial begin
    int n;
    req = 1'b0;
    req_data = '0;
    expect_hit = 1'b0;
    timeouts = 0;
    rng_state = 32'd33393;
    n = 0;
    while (reset && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (n == WAIT_LIMIT) begin
      timeouts++;
      $display("timeout: reset never released");
    end
    // quiet period before the first request
    repeat (10) @(posedge clk);

    issue(STORE, W, 16'h0000, 32'h1122_3344);
    issue(STORE, B, 16'h0002, 32'h0000_00ee);
    issue(LOAD, W, 16'h0000, '0);
    issue(LOAD, B, 16'h0002, '0);
    issue(LOAD, B, 16'h0003, '0);
    // same set, other tags
    issue(STORE, W, 16'h0080, 32'hdead_beef);
    issue(STORE, W, 16'h0104, 32'hcafe_f00d);
    issue(LOAD, W, 16'h0000, '0);
    issue(LOAD, W, 16'h0080, '0);
    issue(LOAD, W, 16'h0104, '0);

    issue(LOAD, W, 16'h0040, '0);
    // line now resident and the buffer empty
    expect_hit <= 1'b1;
    issue(LOAD, W, 16'h0044, '0);
    expect_hit <= 1'b0;

    for (int i = 0; i < 10; i++) begin
      issue(STORE, W, ADDRESS_WIDTH'(16'h0200 + i * 16'h0084), 32'h5000_0000 + i);
    end
    for (int i = 0; i < 10; i++) begin
      issue(LOAD, W, ADDRESS_WIDTH'(16'h0200 + i * 16'h0084), '0);
    end

    for (int i = 0; i < 400; i++) begin
      logic [ADDRESS_WIDTH-1:0] a;
      r = next_rand();
      a = {6'b0, r[25:16]};
      if (!r[9]) a[1:0] = 2'b00;
      issue(r[8] ? STORE : LOAD, r[9] ? B : W, a, next_rand());
    end
    repeat (20) @(posedge clk);

    $display("closing: %0d check errors, %0d timeouts", error_count, timeouts);
    if (error_count == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
